//--- Makefile
# Verilator build and run of the block looper testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_accum_block_looper
FILELIST  = all.f
OBJ_DIR   = obj_dir

SIM  = $(OBJ_DIR)/V$(TOP)
SRCS = $(shell grep '\.sv$$' $(FILELIST))
PASS = *** PASSED ***

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out=$$(./$(SIM) 2>&1) || true; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS)'

clean:
	rm -rf $(OBJ_DIR)

//--- all.f
rtl/tau_pkg.sv
rtl/grid_walker.sv
rtl/block_broadcast.sv
rtl/channel_issue.sv
rtl/block_done_tracker.sv
rtl/accum_block_looper.sv
tests/accum_block_looper_assert.sv
tests/tb_accum_block_looper.sv

//--- rtl/accum_block_looper.sv
// Command inputs must hold until o_src_ack; all channels share one ID width and walk from offset 0
`timescale 1ns/10ps

module accum_block_looper
	import tau_pkg::*;
#(
	parameter int VDIM    = tau_pkg::VDIM,
	parameter int N_CH    = tau_pkg::N_CH,
	parameter int WORK_BW = tau_pkg::WORK_BW
) (
	input  logic            i_clk,
	input  logic            i_arst_n,
	// Command
	input  logic            i_src_rdy,
	output logic            o_src_ack,
	input  grid_cfg_t       i_grid,
	input  chan_cfg_t       i_chan_cfg [N_CH],
	// Channel ports
	output logic [N_CH-1:0] o_ch_rdy,
	input  logic [N_CH-1:0] i_ch_ack,
	output block_t          o_ch_blk [N_CH],
	output logic            o_blkdone
);

	// ========================================
	// Internal
	// ========================================
	logic            walk_rdy;
	logic            walk_ack;
	walk_t           walk;
	logic [N_CH-1:0] bc_rdy;
	logic [N_CH-1:0] bc_ack;
	logic [N_CH-1:0] retire;
	logic [N_CH-1:0] retire_last;

	// ========================================
	// Block walk and fan-out
	// ========================================
	grid_walker #(
		.VDIM    (VDIM),
		.WORK_BW (WORK_BW)
	) u_walker (
		.i_clk      (i_clk),
		.i_arst_n   (i_arst_n),
		.i_src_rdy  (i_src_rdy),
		.o_src_ack  (o_src_ack),
		.i_grid     (i_grid),
		.o_walk_rdy (walk_rdy),
		.i_walk_ack (walk_ack),
		.o_walk     (walk)
	);

	block_broadcast #(
		.N_CH (N_CH)
	) u_bcast (
		.i_clk     (i_clk),
		.i_arst_n  (i_arst_n),
		.i_src_rdy (walk_rdy),
		.o_src_ack (walk_ack),
		.o_dst_rdy (bc_rdy),
		.i_dst_ack (bc_ack)
	);

	// ========================================
	// Channel issuers
	// ========================================
	for (genvar c = 0; c < N_CH; c++) begin : g_ch
		channel_issue u_issue (
			.i_clk         (i_clk),
			.i_arst_n      (i_arst_n),
			.i_src_rdy     (bc_rdy[c]),
			.o_src_ack     (bc_ack[c]),
			.i_walk        (walk),
			.i_bofs        (i_grid.bofs),
			.i_cfg         (i_chan_cfg[c]),
			.o_rdy         (o_ch_rdy[c]),
			.i_ack         (i_ch_ack[c]),
			.o_blk         (o_ch_blk[c]),
			.o_retire      (retire[c]),
			.o_retire_last (retire_last[c])
		);
	end

	block_done_tracker #(
		.N_CH (N_CH)
	) u_done (
		.i_clk         (i_clk),
		.i_arst_n      (i_arst_n),
		.i_retire      (retire),
		.i_retire_last (retire_last),
		.o_blkdone     (o_blkdone)
	);

endmodule

//--- rtl/block_broadcast.sv
// Source data must stay stable while i_src_rdy is high; each channel takes the block exactly once
`timescale 1ns/10ps

module block_broadcast #(
	parameter int N_CH = tau_pkg::N_CH
) (
	input  logic            i_clk,
	input  logic            i_arst_n,
	input  logic            i_src_rdy,
	output logic            o_src_ack,
	output logic [N_CH-1:0] o_dst_rdy,
	input  logic [N_CH-1:0] i_dst_ack
);

	// ========================================
	// Internal
	// ========================================
	// One bit per channel that already took the current block
	logic [N_CH-1:0] taken_r;
	logic [N_CH-1:0] taken_now;

	// ========================================
	// Combinational
	// ========================================
	assign o_dst_rdy = {N_CH{i_src_rdy}} & ~taken_r;
	assign taken_now = taken_r | i_dst_ack;

	// Complete in the cycle the last outstanding channel acks
	assign o_src_ack = i_src_rdy && (&taken_now);

	// ========================================
	// Sequential
	// ========================================
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			taken_r <= '0;
		end else if (o_src_ack) begin
			taken_r <= '0;
		end else begin
			taken_r <= taken_now;
		end
	end

endmodule

//--- rtl/block_done_tracker.sv
// A channel may retire the last block of the next command before slower channels finish the current one
`timescale 1ns/10ps

module block_done_tracker #(
	parameter int N_CH = tau_pkg::N_CH
) (
	input  logic            i_clk,
	input  logic            i_arst_n,
	input  logic [N_CH-1:0] i_retire,
	input  logic [N_CH-1:0] i_retire_last,
	output logic            o_blkdone
);

	// ========================================
	// Internal
	// ========================================
	// Per channel, last blocks retired and not yet reported (0 to 2)
	logic [1:0]      last_cnt_r [N_CH];
	logic [N_CH-1:0] got_last;
	logic [N_CH-1:0] have_last;
	logic            all_done;

	// ========================================
	// Combinational
	// ========================================
	always_comb begin
		for (int c = 0; c < N_CH; c++) begin
			got_last[c] = i_retire[c] && i_retire_last[c];
			have_last[c] = (last_cnt_r[c] != 2'd0) || got_last[c];
		end
	end

	assign all_done = &have_last;

	// ========================================
	// Sequential
	// ========================================
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			for (int c = 0; c < N_CH; c++) begin
				last_cnt_r[c] <= 2'd0;
			end
			o_blkdone <= 1'b0;
		end else begin
			for (int c = 0; c < N_CH; c++) begin
				last_cnt_r[c] <= last_cnt_r[c] + {1'b0, got_last[c]} - {1'b0, all_done};
			end
			o_blkdone <= all_done;
		end
	end

endmodule

//--- rtl/channel_issue.sv
// One-entry output stage; a skipped last block waits one cycle if it would retire together with another last
`timescale 1ns/10ps

module channel_issue
	import tau_pkg::*;
(
	input  logic      i_clk,
	input  logic      i_arst_n,
	input  logic      i_src_rdy,
	output logic      o_src_ack,
	input  walk_t     i_walk,
	input  ofs_vec_t  i_bofs,
	input  chan_cfg_t i_cfg,
	output logic      o_rdy,
	input  logic      i_ack,
	output block_t    o_blk,
	output logic      o_retire,
	output logic      o_retire_last
);

	// ========================================
	// Internal
	// ========================================
	logic [ID_BW-1:0] id_beg;
	logic [ID_BW-1:0] id_end;
	logic             empty;
	logic             hold_skip;
	logic             skip;
	logic             load;
	logic             rdy_r;
	logic             last_r;

	// ========================================
	// ID range select
	// ========================================
	assign id_beg = i_cfg.id_begs[i_walk.lvl_beg];
	assign id_end = i_cfg.id_ends[i_walk.lvl_end];
	assign empty = id_beg == id_end;

	// Two last retires in one cycle would merge into one pulse
	assign hold_skip = i_walk.last && i_ack && last_r;

	assign o_src_ack = i_src_rdy && (empty ? !hold_skip : (!rdy_r || i_ack));
	assign skip = o_src_ack && empty;
	assign load = o_src_ack && !empty;

	assign o_rdy = rdy_r;
	assign o_retire = skip || i_ack;
	assign o_retire_last = (skip && i_walk.last) || (i_ack && last_r);

	// ========================================
	// Sequential
	// ========================================
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			rdy_r <= 1'b0;
			last_r <= 1'b0;
		end else if (load) begin
			rdy_r <= 1'b1;
			last_r <= i_walk.last;
		end else if (i_ack) begin
			rdy_r <= 1'b0;
			last_r <= 1'b0;
		end
	end

	// Block payload
	always_ff @(posedge i_clk) begin
		if (load) begin
			o_blk.bofs <= i_bofs;
			o_blk.aofs_beg <= i_walk.aofs_beg;
			o_blk.aofs_end <= i_walk.aofs_end;
			o_blk.id_beg <= id_beg;
			o_blk.id_end <= id_end;
		end
	end

endmodule

//--- rtl/grid_walker.sv
// Walks blocks from offset 0 with dimension 0 fastest; a zero step never reaches a non-zero grid end
`timescale 1ns/10ps

module grid_walker
	import tau_pkg::*;
#(
	parameter int VDIM    = tau_pkg::VDIM,
	parameter int WORK_BW = tau_pkg::WORK_BW
) (
	input  logic      i_clk,
	input  logic      i_arst_n,
	input  logic      i_src_rdy,
	output logic      o_src_ack,
	input  grid_cfg_t i_grid,
	output logic      o_walk_rdy,
	input  logic      i_walk_ack,
	output walk_t     o_walk
);

	// ========================================
	// State
	// ========================================
	walk_state_e     state_r;
	ofs_vec_t        ofs_r;
	ofs_vec_t        nxt_ofs;
	ofs_vec_t        aofs_end;
	logic [VDIM-1:0] first_pos;
	logic [VDIM-1:0] last_pos;
	logic [VDIM-1:0] nxt_last_pos;
	logic [LVL_BW-1:0] lvl_beg;
	logic [LVL_BW-1:0] lvl_end;

	// ========================================
	// Offsets and odometer step
	// ========================================
	always_comb begin
		logic [WORK_BW:0] sum;
		logic [WORK_BW:0] nxt_sum;
		logic             carry;
		carry = 1'b1;
		for (int d = 0; d < VDIM; d++) begin
			sum = {1'b0, ofs_r[d]} + {1'b0, i_grid.agrid_step[d]};
			first_pos[d] = ofs_r[d] == '0;
			last_pos[d] = sum >= {1'b0, i_grid.agrid_end[d]};
			// Clip the block end at the tensor boundary
			if (sum > {1'b0, i_grid.aboundary[d]}) begin
				aofs_end[d] = i_grid.aboundary[d];
			end else begin
				aofs_end[d] = sum[WORK_BW-1:0];
			end
			// Wrap finished dims, advance the first one that can move
			if (!carry) begin
				nxt_ofs[d] = ofs_r[d];
			end else if (last_pos[d]) begin
				nxt_ofs[d] = '0;
			end else begin
				nxt_ofs[d] = sum[WORK_BW-1:0];
				carry = 1'b0;
			end
			nxt_sum = {1'b0, nxt_ofs[d]} + {1'b0, i_grid.agrid_step[d]};
			nxt_last_pos[d] = nxt_sum >= {1'b0, i_grid.agrid_end[d]};
		end
	end

	// Loop levels count the leading run of dims at their first/last position
	always_comb begin
		logic stop_beg;
		logic stop_end;
		stop_beg = 1'b0;
		stop_end = 1'b0;
		lvl_beg = '0;
		lvl_end = '0;
		for (int d = 0; d < VDIM; d++) begin
			if (!stop_beg && first_pos[d]) begin
				lvl_beg = lvl_beg + 1'b1;
			end else begin
				stop_beg = 1'b1;
			end
			if (!stop_end && last_pos[d]) begin
				lvl_end = lvl_end + 1'b1;
			end else begin
				stop_end = 1'b1;
			end
		end
	end

	assign o_walk_rdy = state_r != IDLE;
	assign o_src_ack = (state_r == WAIT_LAST) && i_walk_ack;
	assign o_walk.aofs_beg = ofs_r;
	assign o_walk.aofs_end = aofs_end;
	assign o_walk.lvl_beg = lvl_beg;
	assign o_walk.lvl_end = lvl_end;
	assign o_walk.last = state_r == WAIT_LAST;

	// ========================================
	// Sequential
	// ========================================
	// Counters are back at zero whenever the walker is idle
	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state_r <= IDLE;
			ofs_r <= '0;
		end else begin
			unique case (state_r)
				IDLE: if (i_src_rdy) begin
					state_r <= (&last_pos) ? WAIT_LAST : RUN;
				end
				RUN: if (i_walk_ack) begin
					ofs_r <= nxt_ofs;
					if (&nxt_last_pos) begin
						state_r <= WAIT_LAST;
					end
				end
				WAIT_LAST: if (i_walk_ack) begin
					ofs_r <= nxt_ofs;
					state_r <= IDLE;
				end
				default: state_r <= IDLE;
			endcase
		end
	end

endmodule

//--- rtl/tau_pkg.sv
// Widths and record layouts of the looper; module parameters VDIM, N_CH and WORK_BW must match these
package tau_pkg;

	// ========================================
	// Widths
	// ========================================
	parameter int WORK_BW = 16;
	parameter int VDIM    = 2;
	parameter int N_CH    = 4;
	parameter int ID_BW   = 4;
	// Loop level runs from 0 to VDIM inclusive
	parameter int LVL_BW  = $clog2(VDIM + 1);

	// ========================================
	// Command records
	// ========================================
	typedef logic [VDIM-1:0][WORK_BW-1:0] ofs_vec_t;

	typedef struct packed {
		ofs_vec_t bofs;
		ofs_vec_t agrid_step;
		ofs_vec_t agrid_end;
		ofs_vec_t aboundary;
	} grid_cfg_t;

	// ID table, one entry per loop level
	typedef logic [VDIM:0][ID_BW-1:0] id_tab_t;

	typedef struct packed {
		id_tab_t id_begs;
		id_tab_t id_ends;
	} chan_cfg_t;

	// ========================================
	// Block records
	// ========================================
	typedef struct packed {
		ofs_vec_t          aofs_beg;
		ofs_vec_t          aofs_end;
		logic [LVL_BW-1:0] lvl_beg;
		logic [LVL_BW-1:0] lvl_end;
		logic              last;
	} walk_t;

	typedef struct packed {
		ofs_vec_t         bofs;
		ofs_vec_t         aofs_beg;
		ofs_vec_t         aofs_end;
		logic [ID_BW-1:0] id_beg;
		logic [ID_BW-1:0] id_end;
	} block_t;

	// Walker FSM where WAIT_LAST presents the final block of a command
	typedef enum logic [1:0] {
		IDLE,
		RUN,
		WAIT_LAST
	} walk_state_e;

endpackage

//--- tests/accum_block_looper_assert.sv
// Handshake rules are checked only outside reset; needs a simulator run with assertions enabled
`timescale 1ns/10ps

module accum_block_looper_assert
	import tau_pkg::*;
#(
	parameter int N_CH = tau_pkg::N_CH
) (
	input logic            i_clk,
	input logic            i_arst_n,
	input logic            i_src_rdy,
	input logic            i_src_ack,
	input logic [N_CH-1:0] i_ch_rdy,
	input logic [N_CH-1:0] i_ch_ack,
	input block_t          i_ch_blk [N_CH]
);

	// ========================================
	// Command port
	// ========================================
	a_src_ack: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		i_src_ack |-> i_src_rdy)
		else $error("o_src_ack pulsed while no command was presented");

	a_src_hold: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		i_src_rdy && !i_src_ack |=> i_src_rdy)
		else $error("i_src_rdy dropped before o_src_ack");

	// ========================================
	// Channel ports
	// ========================================
	for (genvar c = 0; c < N_CH; c++) begin : g_ch
		a_rdy_hold: assert property (@(posedge i_clk) disable iff (!i_arst_n)
			i_ch_rdy[c] && !i_ch_ack[c] |=> i_ch_rdy[c])
			else $error("o_ch_rdy[%0d] dropped before its ack", c);

		a_ack_rdy: assert property (@(posedge i_clk) disable iff (!i_arst_n)
			i_ch_ack[c] |-> i_ch_rdy[c])
			else $error("i_ch_ack[%0d] pulsed without o_ch_rdy", c);

		// Payload frozen while waiting for the consumer
		a_blk_stable: assert property (@(posedge i_clk) disable iff (!i_arst_n)
			i_ch_rdy[c] && !i_ch_ack[c] |=> $stable(i_ch_blk[c]))
			else $error("o_ch_blk[%0d] changed while waiting for ack", c);
	end

endmodule

bind accum_block_looper accum_block_looper_assert #(
	.N_CH (N_CH)
) u_assert (
	.i_clk     (i_clk),
	.i_arst_n  (i_arst_n),
	.i_src_rdy (i_src_rdy),
	.i_src_ack (o_src_ack),
	.i_ch_rdy  (o_ch_rdy),
	.i_ch_ack  (i_ch_ack),
	.i_ch_blk  (o_ch_blk)
);

//--- tests/tb_accum_block_looper.sv
// Directed tests are written for VDIM = 2 and N_CH = 4; consumers ack at the earliest one cycle after rdy
`timescale 1ns/10ps

module tb_accum_block_looper
	import tau_pkg::*;
();

	// ========================================
	// DUT and stimulus signals
	// ========================================
	localparam int CLK_HALF   = 4;
	localparam int RST_CYCLES = 4;

	logic            clk;
	logic            arst_n;
	logic            src_rdy;
	logic            src_ack;
	grid_cfg_t       grid;
	chan_cfg_t       chan_cfg [N_CH];
	logic [N_CH-1:0] ch_rdy;
	logic [N_CH-1:0] ch_ack = '0;
	block_t          ch_blk [N_CH];
	logic            blkdone;

	// Reference model state
	chan_cfg_t cmd_cfg [N_CH];
	block_t    exp_q [N_CH][$];
	int        exp_total [N_CH] = '{default: 0};
	int        got_total [N_CH] = '{default: 0};
	int        stall_pct [N_CH] = '{default: 0};
	int        exp_done = 0;
	int        done_cnt = 0;
	int        exp_acks = 0;
	int        ack_cnt = 0;
	int        cycles = 0;
	int        cycle_limit = 200;

	accum_block_looper #(
		.VDIM    (VDIM),
		.N_CH    (N_CH),
		.WORK_BW (WORK_BW)
	) DUT (
		.i_clk      (clk),
		.i_arst_n   (arst_n),
		.i_src_rdy  (src_rdy),
		.o_src_ack  (src_ack),
		.i_grid     (grid),
		.i_chan_cfg (chan_cfg),
		.o_ch_rdy   (ch_rdy),
		.i_ch_ack   (ch_ack),
		.o_ch_blk   (ch_blk),
		.o_blkdone  (blkdone)
	);

	initial begin
		clk = 1'b0;
		forever #CLK_HALF clk = ~clk;
	end

	// ========================================
	// Checks
	// ========================================
	task automatic fail_run();
		$display("*** FAILED ***");
		$fatal(1, "Stopping at the first error");
	endtask

	task automatic check_block(input string name, input block_t got, input block_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s got bofs=%h beg=%h end=%h id=%h..%h", name,
				got.bofs, got.aofs_beg, got.aofs_end, got.id_beg, got.id_end);
			$display("  expected bofs=%h beg=%h end=%h id=%h..%h",
				exp.bofs, exp.aofs_beg, exp.aofs_end, exp.id_beg, exp.id_end);
			fail_run();
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s got %h exp %h", name, got, exp);
			fail_run();
		end
	endtask

	// ========================================
	// Reference model of the walk
	// ========================================
	function automatic ofs_vec_t make_vec(input logic [WORK_BW-1:0] d0,
		input logic [WORK_BW-1:0] d1);
		ofs_vec_t v;
		v[0] = d0;
		v[1] = d1;
		return v;
	endfunction

	function automatic id_tab_t make_tab(input int l0, input int l1, input int l2);
		id_tab_t t;
		t[0] = ID_BW'(l0);
		t[1] = ID_BW'(l1);
		t[2] = ID_BW'(l2);
		return t;
	endfunction

	// Appends the expected blocks of one command to every channel queue
	task automatic model_cmd(input grid_cfg_t g);
		int                pos [VDIM];
		int                beg_v;
		int                end_v;
		logic [VDIM-1:0]   at_last;
		logic [LVL_BW-1:0] lvl_b;
		logic [LVL_BW-1:0] lvl_e;
		logic              run_b;
		logic              run_e;
		logic              wrapped;
		block_t            blk;
		for (int d = 0; d < VDIM; d++) begin
			pos[d] = 0;
		end
		blk.bofs = g.bofs;
		wrapped = 1'b0;
		while (!wrapped) begin
			lvl_b = '0;
			lvl_e = '0;
			run_b = 1'b1;
			run_e = 1'b1;
			for (int d = 0; d < VDIM; d++) begin
				beg_v = pos[d];
				end_v = beg_v + int'(g.agrid_step[d]);
				at_last[d] = end_v >= int'(g.agrid_end[d]);
				if (end_v > int'(g.aboundary[d])) begin
					end_v = int'(g.aboundary[d]);
				end
				blk.aofs_beg[d] = beg_v[WORK_BW-1:0];
				blk.aofs_end[d] = end_v[WORK_BW-1:0];
				// Levels count the unbroken run from dimension 0
				run_b = run_b && (beg_v == 0);
				run_e = run_e && at_last[d];
				if (run_b) begin
					lvl_b = lvl_b + LVL_BW'(1);
				end
				if (run_e) begin
					lvl_e = lvl_e + LVL_BW'(1);
				end
			end
			for (int c = 0; c < N_CH; c++) begin
				blk.id_beg = cmd_cfg[c].id_begs[lvl_b];
				blk.id_end = cmd_cfg[c].id_ends[lvl_e];
				if (blk.id_beg != blk.id_end) begin
					exp_q[c].push_back(blk);
					exp_total[c]++;
				end
			end
			cycle_limit += 20;
			// Odometer step with dimension 0 fastest
			wrapped = 1'b1;
			for (int d = 0; d < VDIM; d++) begin
				if (wrapped) begin
					if (at_last[d]) begin
						pos[d] = 0;
					end else begin
						pos[d] += int'(g.agrid_step[d]);
						wrapped = 1'b0;
					end
				end
			end
		end
		exp_done++;
		exp_acks++;
	endtask

	// ========================================
	// Command source and consumers
	// ========================================
	// Called at a rising edge, returns at the edge that ends the command transfer
	task automatic send_cmd(input grid_cfg_t g);
		model_cmd(g);
		src_rdy <= 1'b1;
		grid <= g;
		for (int c = 0; c < N_CH; c++) begin
			chan_cfg[c] <= cmd_cfg[c];
		end
		do begin
			@(posedge clk);
		end while (!src_ack);
	endtask

	task automatic idle_src();
		src_rdy <= 1'b0;
	endtask

	task automatic take_block(input int c);
		block_t exp;
		if (exp_q[c].size() == 0) begin
			$display("Channel %0d delivered a block that was not expected", c);
			fail_run();
		end else begin
			exp = exp_q[c].pop_front();
			check_block($sformatf("o_ch_blk[%0d]", c), ch_blk[c], exp);
			got_total[c]++;
		end
	endtask

	// Acks for one cycle once a random draw clears the channel's stall rate
	initial begin
		void'($urandom(32'h16293596));
		forever begin
			@(posedge clk);
			for (int c = 0; c < N_CH; c++) begin
				if (ch_rdy[c] && ch_ack[c]) begin
					take_block(c);
					ch_ack[c] <= 1'b0;
				end else if (ch_rdy[c] && (($urandom % 100) >= stall_pct[c])) begin
					ch_ack[c] <= 1'b1;
				end
			end
		end
	end

	always @(negedge clk) begin
		if (blkdone) begin
			done_cnt++;
		end
		if (src_ack) begin
			ack_cnt++;
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > cycle_limit) begin
			$display("Timeout after %0d cycles, the looper stopped delivering blocks", cycles);
			fail_run();
		end
	end

	task automatic wait_done();
		while (done_cnt < exp_done) begin
			@(posedge clk);
		end
	endtask

	task automatic check_totals();
		for (int c = 0; c < N_CH; c++) begin
			check_count($sformatf("blocks on channel %0d", c), got_total[c], exp_total[c]);
		end
		check_count("o_blkdone pulses", done_cnt, exp_done);
		check_count("o_src_ack pulses", ack_cnt, exp_acks);
	endtask

	// ========================================
	// Directed tests
	// ========================================
	task automatic cfg_distinct();
		for (int c = 0; c < N_CH; c++) begin
			cmd_cfg[c].id_begs = make_tab(c, c + 1, c + 2);
			cmd_cfg[c].id_ends = make_tab(c + 8, c + 9, c + 10);
		end
	endtask

	// Channel 1 empty at level end 0, channel 2 at levels 0/0, channel 3 everywhere
	task automatic cfg_sparse();
		cmd_cfg[0].id_begs = make_tab(0, 1, 2);
		cmd_cfg[0].id_ends = make_tab(4, 5, 6);
		cmd_cfg[1].id_begs = make_tab(5, 5, 5);
		cmd_cfg[1].id_ends = make_tab(5, 7, 7);
		cmd_cfg[2].id_begs = make_tab(1, 2, 3);
		cmd_cfg[2].id_ends = make_tab(1, 5, 6);
		cmd_cfg[3].id_begs = make_tab(9, 9, 9);
		cmd_cfg[3].id_ends = make_tab(9, 9, 9);
	endtask

	task automatic run_one(input grid_cfg_t g);
		send_cmd(g);
		idle_src();
		wait_done();
		check_totals();
	endtask

	task automatic test_single_block();
		grid_cfg_t g;
		stall_pct = '{0, 0, 0, 0};
		cfg_distinct();
		g.bofs = make_vec(16'h0040, 16'h0100);
		g.agrid_step = make_vec(20, 20);
		g.agrid_end = make_vec(12, 10);
		g.aboundary = make_vec(15, 8);
		run_one(g);
	endtask

	task automatic test_grid_3x2();
		grid_cfg_t g;
		stall_pct = '{0, 0, 0, 0};
		cfg_distinct();
		g.bofs = make_vec(16'h1234, 16'h0abc);
		g.agrid_step = make_vec(4, 3);
		g.agrid_end = make_vec(12, 6);
		g.aboundary = make_vec(10, 6);
		run_one(g);
	endtask

	task automatic test_sparse_ranges();
		grid_cfg_t g;
		stall_pct = '{0, 0, 0, 0};
		cfg_sparse();
		g.bofs = make_vec(16'h0007, 16'h0300);
		g.agrid_step = make_vec(4, 3);
		g.agrid_end = make_vec(12, 6);
		g.aboundary = make_vec(12, 5);
		run_one(g);
	endtask

	task automatic test_random_stalls();
		grid_cfg_t g;
		stall_pct = '{25, 50, 70, 10};
		cfg_distinct();
		cmd_cfg[1].id_ends = make_tab(1, 10, 11);
		g.bofs = make_vec(16'hbeef, 16'h0042);
		g.agrid_step = make_vec(4, 3);
		g.agrid_end = make_vec(16, 9);
		g.aboundary = make_vec(14, 8);
		run_one(g);
	endtask

	task automatic test_back_to_back();
		grid_cfg_t ga;
		grid_cfg_t gb;
		stall_pct = '{0, 40, 0, 20};
		ga.bofs = make_vec(16'h0a00, 16'h0b00);
		ga.agrid_step = make_vec(4, 2);
		ga.agrid_end = make_vec(8, 4);
		ga.aboundary = make_vec(8, 3);
		gb.bofs = make_vec(16'h0c00, 16'h0d00);
		gb.agrid_step = make_vec(3, 8);
		gb.agrid_end = make_vec(9, 5);
		gb.aboundary = make_vec(9, 5);
		cfg_distinct();
		send_cmd(ga);
		// Second command follows in the same cycle as the first ack
		cfg_sparse();
		send_cmd(gb);
		idle_src();
		wait_done();
		check_totals();
	endtask

	initial begin
		arst_n = 1'b0;
		src_rdy = 1'b0;
		grid = '0;
		for (int c = 0; c < N_CH; c++) begin
			chan_cfg[c] = '0;
		end
		repeat (RST_CYCLES) @(posedge clk);
		arst_n <= 1'b1;
		@(posedge clk);
		test_single_block();
		test_grid_3x2();
		test_sparse_ranges();
		test_random_stalls();
		test_back_to_back();
		// Quiet window to catch stray done or ack pulses
		repeat (8) @(posedge clk);
		check_totals();
		$display("*** PASSED ***");
		$finish;
	end

endmodule
